/* Makefile */
# Verilator build and run of the LED manager testbench

TOP := led_mgr_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	grep -qx "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* all.f */
hdl/led_pkg.sv
hdl/led_ctl_if.sv
hdl/led_tick_gen.sv
hdl/led_cfg_regs.sv
hdl/led_chan_bank.sv
hdl/led_board_status.sv
hdl/led_mgr_top.sv
dv/led_clk_gen.sv
dv/led_mgr_tb.sv

/* dv/led_clk_gen.sv */
// Testbench clock and power-on reset source, instantiated once by the testbench top
`default_nettype none

module led_clk_gen #(
    parameter int unsigned period_ns  = 100,  // Clock period
    parameter int unsigned rst_cycles = 8     // Rising edges held in reset
) (
    output logic clk_sys,
    output logic rst_sys_n
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk_sys = 1'b0;
        forever begin
            #(period_ns / 2) clk_sys = ~clk_sys;
        end
    end

    // Release lands on a falling edge, clear of the active edge
    initial begin
        rst_sys_n = 1'b0;
        repeat (rst_cycles) @(posedge clk_sys);
        @(negedge clk_sys);
        rst_sys_n = 1'b1;
    end

endmodule : led_clk_gen

`default_nettype wire

/* dv/led_mgr_tb.sv */
// Self-checking testbench for the LED manager, replaying tick windows from the test data file
`default_nettype none

module led_mgr_tb
    import led_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int unsigned win_len     = 9;  // 2^(4-1)+1 cycles with tick_cnt_w = 4
    localparam int unsigned pulse_first = 1;  // Earliest pulse cycle in a window
    localparam int unsigned pulse_last  = 6;  // Latest, well clear of the tick
    localparam string       data_path   = "dv/led_mgr_testdata.txt";

    logic                  clk_sys;
    logic                  rst_sys_n;
    logic [num_slot-1:0]   enable_slot;
    logic                  cfg_en;
    logic                  self_cfg_err;
    logic [num_lvds-1:0]   lvds_rx_eop;
    logic [num_lvds-1:0]   lvds_slink_err;
    logic [num_fiber-1:0]  fiber_tx_eop;
    logic [num_fiber-1:0]  fiber_rx_eop;
    logic [num_fiber-1:0]  fiber_slink_err;
    logic [num_ex-1:0]     ex_rx_eop;
    logic [num_ex-1:0]     ex_slink_err;
    logic [2*num_chan-1:0] chan_led;
    logic                  run_led;
    logic                  err_led;

    // Window table, one entry per data line
    logic [num_slot-1:0]   win_slot    [$];
    logic                  win_cfg_en  [$];
    logic                  win_fault   [$];
    logic [num_chan-1:0]   win_act     [$];
    logic [num_chan-1:0]   win_err     [$];
    logic [2*num_chan-1:0] win_exp_led [$];
    logic                  win_exp_run [$];
    logic                  win_exp_err [$];

    int unsigned cyc_cnt   = 0;     // Clock edges since time zero
    int unsigned cyc_limit = 0;     // Zero until the data is loaded

    led_clk_gen #(
        .period_ns  (100),
        .rst_cycles (8)
    ) i_clk_gen (
        .clk_sys   (clk_sys),
        .rst_sys_n (rst_sys_n)
    );

    led_mgr_top #(
        .tick_cnt_w (4)
    ) i_dut (
        .clk_sys         (clk_sys),
        .rst_sys_n       (rst_sys_n),
        .enable_slot     (enable_slot),
        .cfg_en          (cfg_en),
        .self_cfg_err    (self_cfg_err),
        .lvds_rx_eop     (lvds_rx_eop),
        .lvds_slink_err  (lvds_slink_err),
        .fiber_tx_eop    (fiber_tx_eop),
        .fiber_rx_eop    (fiber_rx_eop),
        .fiber_slink_err (fiber_slink_err),
        .ex_rx_eop       (ex_rx_eop),
        .ex_slink_err    (ex_slink_err),
        .chan_led        (chan_led),
        .run_led         (run_led),
        .err_led         (err_led)
    );

    // ----------------------------------------
    // Failure and compare helpers
    // ----------------------------------------
    task automatic abort_run();
        $display("sim failed");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_chan_led(input int unsigned win, input int unsigned ch,
                                  input led_color_e got, input led_color_e exp);
        if (got !== exp) begin
            $display("** Error: window %0d chan_led[%0d] got 0x%h expected 0x%h",
                     win, ch, got, exp);
            abort_run();
        end
    endtask

    task automatic check_bit(input int unsigned win, input string name,
                             input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error: window %0d %s got 0x%h expected 0x%h", win, name, got, exp);
            abort_run();
        end
    endtask

    // Whole panel against one data line
    task automatic check_window(input int unsigned k);
        logic [2*num_chan-1:0] exp_led;
        exp_led = win_exp_led[k];
        for (int unsigned i = 0; i < num_chan; i++) begin
            check_chan_led(k, i, led_color_e'(chan_led[2*i +: 2]),
                           led_color_e'(exp_led[2*i +: 2]));
        end
        check_bit(k, "run_led", run_led, win_exp_run[k]);
        check_bit(k, "err_led", err_led, win_exp_err[k]);
    endtask

    // Dark panel just out of reset, board strap still low
    task automatic check_reset_panel();
        for (int unsigned i = 0; i < num_chan; i++) begin
            check_chan_led(0, i, led_color_e'(chan_led[2*i +: 2]), led_off);
        end
        check_bit(0, "run_led", run_led, 1'b0);
        check_bit(0, "err_led", err_led, 1'b0);
    endtask

    // ----------------------------------------
    // Stimulus helpers
    // ----------------------------------------
    // Channel masks onto the link pins, index order from the package map
    task automatic drive_pulses(input logic [num_chan-1:0] act, input logic [num_chan-1:0] err);
        lvds_rx_eop        = act[num_lvds-1:0];
        fiber_tx_eop[0]    = act[chan_fiber_tx0];
        fiber_rx_eop[0]    = act[chan_fiber_rx0];
        fiber_tx_eop[1]    = act[chan_fiber_tx1];
        fiber_rx_eop[1]    = act[chan_fiber_rx1];
        ex_rx_eop          = act[chan_ex0 +: num_ex];
        lvds_slink_err     = err[num_lvds-1:0];
        fiber_slink_err[0] = err[chan_fiber_rx0];  // Transmit LEDs have no error pin
        fiber_slink_err[1] = err[chan_fiber_rx1];
        ex_slink_err       = err[chan_ex0 +: num_ex];
    endtask

    task automatic load_windows();
        int                    fd;
        int                    n;
        string                 line;
        logic [num_slot-1:0]   f_slot;
        logic                  f_cfg;
        logic                  f_fault;
        logic [num_chan-1:0]   f_act;
        logic [num_chan-1:0]   f_err;
        logic [2*num_chan-1:0] f_led;
        logic                  f_run;
        logic                  f_err_led;
        fd = $fopen(data_path, "r");
        if (fd == 0) begin
            $display("Cannot open the test data file %s", data_path);
            abort_run();
        end else begin
            while ($fgets(line, fd) != 0) begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h", f_slot, f_cfg, f_fault,
                            f_act, f_err, f_led, f_run, f_err_led);
                if (n == 8) begin
                    win_slot.push_back(f_slot);
                    win_cfg_en.push_back(f_cfg);
                    win_fault.push_back(f_fault);
                    win_act.push_back(f_act);
                    win_err.push_back(f_err);
                    win_exp_led.push_back(f_led);
                    win_exp_run.push_back(f_run);
                    win_exp_err.push_back(f_err_led);
                end else if (n > 0) begin
                    $display("Test data line has %0d fields instead of 8: %s", n, line);
                    abort_run();
                end
            end
            $fclose(fd);
        end
    endtask

    // Watchdog
    always @(posedge clk_sys) begin
        cyc_cnt <= cyc_cnt + 1;
        if (cyc_limit != 0 && cyc_cnt >= cyc_limit) begin
            $display("Timeout: no result after %0d clock cycles", cyc_cnt);
            abort_run();
        end
    end

    // ----------------------------------------
    // Window sequence
    // ----------------------------------------
    initial begin : run_windows
        int unsigned         num_win;
        int unsigned         act_cyc [num_chan];  // Pulse cycle per channel
        int unsigned         err_cyc [num_chan];
        logic [num_chan-1:0] cur_act;
        logic [num_chan-1:0] cur_err;
        enable_slot  = '0;
        cfg_en       = 1'b0;
        self_cfg_err = 1'b0;
        drive_pulses('0, '0);
        void'($urandom(56));
        load_windows();
        num_win = win_slot.size();
        if (num_win == 0) begin
            $display("Test data file holds no windows");
            abort_run();
        end
        cyc_limit = (num_win + 2) * win_len + 20;

        // Window 0 opens one edge after release, its tick lands nine edges later
        @(posedge rst_sys_n);
        @(posedge clk_sys);
        for (int unsigned k = 0; k < num_win; k++) begin
            for (int unsigned p = 0; p < win_len; p++) begin
                @(negedge clk_sys);
                if (p == 0 && k == 0) begin
                    check_reset_panel();  // Straps not yet applied
                end
                if (p == 0) begin
                    enable_slot  = win_slot[k];
                    cfg_en       = win_cfg_en[k];
                    self_cfg_err = win_fault[k];
                    for (int unsigned i = 0; i < num_chan; i++) begin
                        act_cyc[i] = pulse_first + ($urandom % (pulse_last - pulse_first + 1));
                        err_cyc[i] = pulse_first + ($urandom % (pulse_last - pulse_first + 1));
                    end
                end
                if (p == 1 && k > 0) begin
                    check_window(k - 1);  // Previous tick settled, err_led included
                end
                for (int unsigned i = 0; i < num_chan; i++) begin
                    cur_act[i] = win_act[k][i] && (act_cyc[i] == p);
                    cur_err[i] = win_err[k][i] && (err_cyc[i] == p);
                end
                drive_pulses(cur_act, cur_err);
            end
        end
        @(negedge clk_sys);
        @(negedge clk_sys);
        check_window(num_win - 1);

        $display("sim passed");
        $finish;
    end

endmodule : led_mgr_tb

`default_nettype wire

/* dv/led_mgr_testdata.txt */
// slot_en cfg_en self_cfg_err act_mask err_mask exp_chan_led run_led err_led (all hex)
// One line per tick window; chan_led holds two bits per channel, channel 0 lowest
1ffff 1 0 00000 00000 5555555555 1 0
0bff7 1 0 00000 00000 0505555515 1 0
1ffff 1 0 4c00b 00000 5555555550 1 0
1ffff 1 0 1000b 00000 5455555515 1 0
1ffff 1 0 00004 00000 5555555545 1 0
1ffff 1 0 000a0 88020 9595551955 1 1
1ffff 1 0 08080 00000 5555555555 1 0
1ffff 1 0 20000 21000 5956555555 1 1
1ffff 1 1 fffff 00001 0000000000 0 0
1ffff 1 1 00010 00000 0000000000 1 0
1ffff 1 1 00000 00000 0000000000 0 0
1ffff 1 0 00000 00000 5555555555 1 0
1ffff 0 0 fffff ebfff 0000000000 0 0
1ffff 0 1 0f0f0 00000 0000000000 0 0
1ffff 1 0 00000 00000 5555555555 1 0
1ffff 1 1 00000 00000 0000000000 0 0
0bff7 1 0 00001 00004 0505555525 1 1
0bff7 1 0 00003 00000 0505555510 1 0
1ffff 1 0 00002 00000 5555555555 1 0
1ffff 1 0 80000 40000 2555555555 1 1
1ffff 0 0 00000 00001 0000000000 0 0

/* hdl/led_board_status.sv */
// Board run LED and summary error LED driven from configuration state and channel red bits
`default_nettype none

module led_board_status
    import led_pkg::*;
(
    input  logic                clk_sys,
    input  logic                rst_sys_n,
    led_ctl_if.status           ctl,
    input  logic [num_chan-1:0] chan_red,  // Red bit of each channel LED
    output logic                run_led,   // Board running
    output logic                err_led    // Any channel in error
);

    // ----------------------------------------
    // Run LED
    // ----------------------------------------
    // Solid when healthy, blinks per window on a self-config fault
    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            run_led <= 1'b0;
        end else begin
            if (!ctl.cfg_on) begin
                run_led <= 1'b0;         // Not configured
            end else if (!ctl.cfg_fault) begin
                run_led <= 1'b1;         // Configured and clean
            end else if (ctl.tick) begin
                run_led <= ~run_led;     // Fault blink
            end
        end
    end

    // ----------------------------------------
    // Error LED
    // ----------------------------------------
    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            err_led <= 1'b0;
        end else begin
            err_led <= |chan_red;  // One cycle behind the channel bank
        end
    end

    // A faulted board blanks channels, so nothing should show red then
    a_no_red_on_fault : assert property (
        @(posedge clk_sys) disable iff (!rst_sys_n)
        (ctl.cfg_fault && $past(ctl.cfg_fault, 2)) |-> !err_led
    ) else $error("error LED lit during self-configuration fault");

endmodule : led_board_status

`default_nettype wire

/* hdl/led_cfg_regs.sv */
// Registers board straps and slot enables, and expands them into the per-channel LED enables
`default_nettype none

module led_cfg_regs
    import led_pkg::*;
(
    input  logic                clk_sys,
    input  logic                rst_sys_n,
    input  logic [num_slot-1:0] enable_slot,   // One strap per slot
    input  logic                cfg_en,        // Board configured
    input  logic                self_cfg_err,  // Self-configuration failed
    led_ctl_if.cfg_src          ctl
);

    logic [num_chan-1:0] slot_chan_en;  // Slot enables spread onto channels
    logic                board_ok;      // Board may show channel LEDs

    // ----------------------------------------
    // Slot to channel expansion
    // ----------------------------------------
    // LVDS slots map one to one
    // Fiber and expansion slots each cover a pair of LEDs
    always_comb begin
        slot_chan_en = '0;
        slot_chan_en[num_lvds-1:0] = enable_slot[num_lvds-1:0];

        // SFF 0 owns slot 14
        slot_chan_en[chan_fiber_tx0] = enable_slot[num_lvds];
        slot_chan_en[chan_fiber_rx0] = enable_slot[num_lvds];

        // SFF 1 owns slot 15
        slot_chan_en[chan_fiber_tx1] = enable_slot[num_lvds+1];
        slot_chan_en[chan_fiber_rx1] = enable_slot[num_lvds+1];

        // Both expansion links share slot 16
        for (int unsigned i = 0; i < num_ex; i++) begin
            slot_chan_en[chan_ex0+i] = enable_slot[num_lvds+2];
        end
    end

    // Unconfigured or failed board blanks every channel
    assign board_ok = cfg_en && !self_cfg_err;

    // ----------------------------------------
    // Output registers
    // ----------------------------------------
    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            ctl.chan_en   <= '0;
            ctl.cfg_on    <= 1'b0;
            ctl.cfg_fault <= 1'b0;
        end else begin
            ctl.chan_en   <= slot_chan_en & {num_chan{board_ok}};  // Masked enables
            ctl.cfg_on    <= cfg_en;
            ctl.cfg_fault <= self_cfg_err;
        end
    end

endmodule : led_cfg_regs

`default_nettype wire

/* hdl/led_chan_bank.sv */
// Sticky activity and error capture with per-window colour update for all channel LEDs
`default_nettype none

module led_chan_bank
    import led_pkg::*;
(
    input  logic                clk_sys,
    input  logic                rst_sys_n,
    led_ctl_if.chan             ctl,
    input  logic [num_chan-1:0] act,                 // Traffic pulses
    input  logic [num_chan-1:0] err,                 // Link error pulses
    output led_color_e          chan_led [num_chan], // Registered LED colour
    output logic [num_chan-1:0] chan_red             // Red bit per channel
);

    logic [num_chan-1:0] act_seen;  // Traffic seen this window
    logic [num_chan-1:0] err_seen;  // Error seen this window

    // ----------------------------------------
    // Flag capture and colour update
    // ----------------------------------------
    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            act_seen <= '0;
            err_seen <= '0;
            for (int unsigned i = 0; i < num_chan; i++) begin
                chan_led[i] <= led_off;
            end
        end else begin
            for (int unsigned i = 0; i < num_chan; i++) begin
                if (!ctl.chan_en[i]) begin
                    // Disabled slot stays dark with nothing remembered
                    chan_led[i] <= led_off;
                    act_seen[i] <= 1'b0;
                    err_seen[i] <= 1'b0;
                end else if (ctl.tick) begin
                    // Close the window
                    if (err_seen[i]) begin
                        chan_led[i] <= led_red;    // Error wins over traffic
                    end else if (act_seen[i]) begin
                        // Blink by flipping green; red or off restarts at green
                        chan_led[i] <= (chan_led[i] == led_green) ? led_off : led_green;
                    end else begin
                        chan_led[i] <= led_green;  // Idle but enabled
                    end
                    act_seen[i] <= act[i];  // Pulse on tick edge opens the new window
                    err_seen[i] <= err[i];
                end else begin
                    act_seen[i] <= act_seen[i] | act[i];  // Sticky until tick
                    err_seen[i] <= err_seen[i] | err[i];
                end
            end
        end
    end

    // Red die state for the board error LED
    always_comb begin
        for (int unsigned i = 0; i < num_chan; i++) begin
            chan_red[i] = chan_led[i][1];
        end
    end

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    for (genvar g = 0; g < num_chan; g++) begin : g_chk
        a_no_both : assert property (
            @(posedge clk_sys) disable iff (!rst_sys_n)
            chan_led[g] != 2'b11
        ) else $error("channel %0d drives red and green together", g);

        // Enable comes from the config block a cycle earlier
        a_off_when_dis : assert property (
            @(posedge clk_sys) disable iff (!rst_sys_n)
            !ctl.chan_en[g] |=> (chan_led[g] == led_off)
        ) else $error("channel %0d lit while disabled", g);
    end

endmodule : led_chan_bank

`default_nettype wire

/* hdl/led_ctl_if.sv */
// Control bundle from the tick and configuration blocks to the channel and board LED logic
`default_nettype none

interface led_ctl_if
    import led_pkg::*;
    ();

    logic                tick;       // One-cycle blink tick
    logic [num_chan-1:0] chan_en;    // Per-channel enable, already masked by board state
    logic                cfg_on;     // Board configured
    logic                cfg_fault;  // Self-configuration failed

    // Blink divider side
    modport tick_src (
        output tick
    );

    // Configuration register side
    modport cfg_src (
        output chan_en,
        output cfg_on,
        output cfg_fault
    );

    // Channel LED bank
    modport chan (
        input tick,
        input chan_en
    );

    // Run and error LEDs
    modport status (
        input tick,
        input cfg_on,
        input cfg_fault
    );

endinterface : led_ctl_if

`default_nettype wire

/* hdl/led_mgr_top.sv */
// Front-panel LED manager top level, gathering link pulses and wiring tick, config and LED blocks
`default_nettype none

module led_mgr_top
    import led_pkg::*;
#(
    parameter int unsigned tick_cnt_w = tick_cnt_w_default  // Blink divider width
) (
    input  logic                  clk_sys,
    input  logic                  rst_sys_n,

    // Board straps
    input  logic [num_slot-1:0]   enable_slot,
    input  logic                  cfg_en,
    input  logic                  self_cfg_err,

    // Link status pulses
    input  logic [num_lvds-1:0]   lvds_rx_eop,
    input  logic [num_lvds-1:0]   lvds_slink_err,
    input  logic [num_fiber-1:0]  fiber_tx_eop,
    input  logic [num_fiber-1:0]  fiber_rx_eop,
    input  logic [num_fiber-1:0]  fiber_slink_err,
    input  logic [num_ex-1:0]     ex_rx_eop,
    input  logic [num_ex-1:0]     ex_slink_err,

    // Panel LEDs
    output logic [2*num_chan-1:0] chan_led,  // Two bits per channel, index order
    output logic                  run_led,
    output logic                  err_led
);

    logic [num_chan-1:0] act;                 // Activity pulses by channel
    logic [num_chan-1:0] err;                 // Error pulses by channel
    logic [num_chan-1:0] chan_red;            // Red bits to the error LED
    led_color_e          chan_led_a [num_chan];

    led_ctl_if ctl_if ();

    // ----------------------------------------
    // Pulse gathering in channel order
    // ----------------------------------------
    assign act[num_lvds-1:0]       = lvds_rx_eop;
    assign act[chan_fiber_tx0]     = fiber_tx_eop[0];
    assign act[chan_fiber_rx0]     = fiber_rx_eop[0];
    assign act[chan_fiber_tx1]     = fiber_tx_eop[1];
    assign act[chan_fiber_rx1]     = fiber_rx_eop[1];
    assign act[chan_ex0 +: num_ex] = ex_rx_eop;

    assign err[num_lvds-1:0]       = lvds_slink_err;
    assign err[chan_fiber_tx0]     = 1'b0;  // Transmit side has no error source
    assign err[chan_fiber_rx0]     = fiber_slink_err[0];
    assign err[chan_fiber_tx1]     = 1'b0;
    assign err[chan_fiber_rx1]     = fiber_slink_err[1];
    assign err[chan_ex0 +: num_ex] = ex_slink_err;

    // Flatten colours onto the panel bus
    for (genvar g = 0; g < num_chan; g++) begin : g_flat
        assign chan_led[2*g +: 2] = chan_led_a[g];
    end

    // ----------------------------------------
    // Blocks
    // ----------------------------------------
    led_tick_gen #(
        .tick_cnt_w (tick_cnt_w)
    ) i_tick_gen (
        .clk_sys    (clk_sys),
        .rst_sys_n  (rst_sys_n),
        .ctl        (ctl_if)
    );

    led_cfg_regs i_cfg_regs (
        .clk_sys      (clk_sys),
        .rst_sys_n    (rst_sys_n),
        .enable_slot  (enable_slot),
        .cfg_en       (cfg_en),
        .self_cfg_err (self_cfg_err),
        .ctl          (ctl_if)
    );

    led_chan_bank i_chan_bank (
        .clk_sys   (clk_sys),
        .rst_sys_n (rst_sys_n),
        .ctl       (ctl_if),
        .act       (act),
        .err       (err),
        .chan_led  (chan_led_a),
        .chan_red  (chan_red)
    );

    led_board_status i_board_status (
        .clk_sys   (clk_sys),
        .rst_sys_n (rst_sys_n),
        .ctl       (ctl_if),
        .chan_red  (chan_red),
        .run_led   (run_led),
        .err_led   (err_led)
    );

endmodule : led_mgr_top

`default_nettype wire

/* hdl/led_pkg.sv */
// Shared channel counts, channel index map and LED colour codes for the LED manager
`default_nettype none

package led_pkg;

    // ----------------------------------------
    // Channel counts
    // ----------------------------------------
    localparam int unsigned num_lvds  = 14;  // Backplane LVDS channels
    localparam int unsigned num_fiber = 2;   // SFF modules, two LEDs each
    localparam int unsigned num_ex    = 2;   // Expansion links
    localparam int unsigned num_slot  = 17;  // Slot enable straps
    localparam int unsigned num_chan  = 20;  // Total channel LEDs

    // ----------------------------------------
    // Channel index map
    // ----------------------------------------
    // LVDS channels sit at 0 to num_lvds-1, fiber and expansion follow
    localparam int unsigned chan_fiber_tx0 = 14;  // SFF 0 transmit
    localparam int unsigned chan_fiber_rx0 = 15;  // SFF 0 receive
    localparam int unsigned chan_fiber_tx1 = 16;  // SFF 1 transmit
    localparam int unsigned chan_fiber_rx1 = 17;  // SFF 1 receive
    localparam int unsigned chan_ex0       = 18;  // First expansion link, second is next

    // ----------------------------------------
    // LED colour code
    // ----------------------------------------
    // Bit 1 drives the red die, bit 0 the green die
    typedef enum logic [1:0] {
        led_off   = 2'b00,
        led_green = 2'b01,
        led_red   = 2'b10   // 11 is never produced
    } led_color_e;

    // Blink divider width
    // 25 bits gives roughly 0.17 s per window at 100 MHz
    localparam int unsigned tick_cnt_w_default = 25;

endpackage : led_pkg

`default_nettype wire

/* hdl/led_tick_gen.sv */
// Free-running divider producing the one-cycle blink tick that frames each LED window
`default_nettype none

module led_tick_gen
    import led_pkg::*;
#(
    parameter int unsigned tick_cnt_w = tick_cnt_w_default
) (
    input  logic           clk_sys,
    input  logic           rst_sys_n,
    led_ctl_if.tick_src    ctl
);

    logic [tick_cnt_w-1:0] tick_cnt;  // Window counter

    // ----------------------------------------
    // Divider
    // ----------------------------------------
    // Counts 0 up to 2^(W-1), so one window is 2^(W-1)+1 cycles
    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            tick_cnt <= '0;
            ctl.tick <= 1'b0;
        end else begin
            if (tick_cnt[tick_cnt_w-1]) begin  // Top bit reached
                tick_cnt <= '0;                 // Restart the window
                ctl.tick <= 1'b1;               // Single pulse
            end else begin
                tick_cnt <= tick_cnt + 1'b1;
                ctl.tick <= 1'b0;
            end
        end
    end

    // Tick is a strobe; the counter restart keeps it from ever stretching
    a_tick_single : assert property (
        @(posedge clk_sys) disable iff (!rst_sys_n)
        ctl.tick |=> !ctl.tick
    ) else $error("blink tick high on two consecutive cycles");

endmodule : led_tick_gen

`default_nettype wire
